// File: build.f
+incdir+testbench
design/bypass_pkg.sv
design/stage_wr_if.sv
design/id_read_if.sv
design/operand_forward.sv
design/hazard_detect.sv
design/issue_ctrl.sv
design/ctrl_bypass_top.sv
testbench/tb_ctrl_bypass.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ctrl_bypass \
  -f build.f -Mdir obj_dir -o sim_tb_ctrl_bypass

./obj_dir/sim_tb_ctrl_bypass | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// File: testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////
// Reference model
//////////////////////////////

// True when an enabled, nonzero source register is produced by a stage
// Register 0 is hard-wired, so it can never be a hit
function automatic logic hits(rf_addr_t addr, logic re, rf_addr_t waddr, logic writes);
  if (!re || !writes) begin
    return 1'b0;
  end
  if (addr == 5'd0) begin
    return 1'b0;
  end
  return addr == waddr;
endfunction

// Fill every expected output from the inputs driven this cycle
task automatic predict();
  logic ex_w;
  logic wb_w;
  logic a_ex;
  logic a_wb;
  logic b_ex;
  logic b_wb;
  logic j_ex;
  logic j_wb;
  ex_w = ex_valid & ex_rf_we;
  wb_w = wb_valid & wb_rf_we;
  a_ex = hits(rs1_addr, rs1_re, ex_waddr, ex_w);
  a_wb = hits(rs1_addr, rs1_re, wb_waddr, wb_w);
  b_ex = hits(rs2_addr, rs2_re, ex_waddr, ex_w);
  b_wb = hits(rs2_addr, rs2_re, wb_waddr, wb_w);
  // A JALR reads rs1 whatever the decoder's read enable says
  j_ex = hits(rs1_addr, 1'b1, ex_waddr, ex_w);
  j_wb = hits(rs1_addr, 1'b1, wb_waddr, wb_w);
  exp_load = ((a_ex | b_ex) & ex_lsu) | ((a_wb | b_wb) & wb_lsu & ~wb_ready);
  exp_jalr = id_valid & id_jalr & (j_ex | (j_wb & wb_lsu));
  exp_csr  = id_valid & id_csr & ((ex_valid & ex_csr) | (wb_valid & wb_csr));
  exp_wfi  = ex_valid & ex_wfi;
  exp_halt = exp_load | exp_jalr | exp_csr | exp_wfi;
  exp_deassert = id_valid & (id_bus_err | id_trigger);
  exp_op_a = FWD_REGFILE;
  exp_op_b = FWD_REGFILE;
  exp_jalr_sel = JALR_REGFILE;
  // Selects only move away from the register file when ID is not halted
  if (!exp_halt) begin
    if (a_ex) exp_op_a = FWD_EX;
    else if (a_wb) exp_op_a = FWD_WB;
    if (b_ex) exp_op_b = FWD_EX;
    else if (b_wb) exp_op_b = FWD_WB;
    if (j_wb) exp_jalr_sel = JALR_WB;
  end
endtask

`endif

// File: testbench/tb_ctrl_bypass.sv
`timescale 1ns/10ps

module tb_ctrl_bypass import bypass_pkg::*; ;

  localparam int HALF_PERIOD  = 10;
  localparam int PERIOD       = 2 * HALF_PERIOD;
  localparam int RESET_CYCLES = 16;
  localparam int VECTORS      = 400;
  localparam int NUM_TESTS    = 5;
  localparam int SEED         = 32'hf99e_04b3;
  // Every test cycle plus reset, with a margin of 100 cycles
  localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS * VECTORS + 100) * PERIOD;

  logic clk;
  logic rst;
  rf_addr_t rs1_addr, rs2_addr, ex_waddr, wb_waddr;
  logic rs1_re, rs2_re, id_valid, id_jalr, id_csr, id_bus_err, id_trigger;
  logic ex_valid, ex_rf_we, ex_lsu, ex_csr, ex_wfi;
  logic wb_valid, wb_rf_we, wb_lsu, wb_csr, wb_ready;
  fwd_sel_e op_a_sel, op_b_sel;
  jalr_sel_e jalr_sel;
  logic load_stall, jalr_stall, csr_stall, wfi_stall, deassert_we, halt_id;

  // Model outputs for the vector in flight
  fwd_sel_e exp_op_a, exp_op_b;
  jalr_sel_e exp_jalr_sel;
  logic exp_load, exp_jalr, exp_csr, exp_wfi, exp_halt, exp_deassert;

  int error_count = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  `include "tb_model.svh"

  ctrl_bypass_top u_dut (
    .clk_i (clk), .rst_i (rst),
    .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr), .rs1_re_i (rs1_re), .rs2_re_i (rs2_re),
    .id_valid_i (id_valid), .id_jalr_i (id_jalr), .id_csr_i (id_csr),
    .id_bus_err_i (id_bus_err), .id_trigger_i (id_trigger),
    .ex_valid_i (ex_valid), .ex_rf_we_i (ex_rf_we), .ex_waddr_i (ex_waddr),
    .ex_lsu_i (ex_lsu), .ex_csr_i (ex_csr), .ex_wfi_i (ex_wfi),
    .wb_valid_i (wb_valid), .wb_rf_we_i (wb_rf_we), .wb_waddr_i (wb_waddr),
    .wb_lsu_i (wb_lsu), .wb_csr_i (wb_csr), .wb_ready_i (wb_ready),
    .op_a_sel_o (op_a_sel), .op_b_sel_o (op_b_sel), .jalr_sel_o (jalr_sel),
    .load_stall_o (load_stall), .jalr_stall_o (jalr_stall), .csr_stall_o (csr_stall),
    .wfi_stall_o (wfi_stall), .deassert_we_o (deassert_we), .halt_id_o (halt_id)
  );

  always #(HALF_PERIOD) clk = ~clk;

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Set with the given chance in percent
  function automatic logic coin(int pct);
    return ($urandom % 100) < pct;
  endfunction

  // Only registers 0 to 3, so hits are frequent and register 0 shows up often
  function automatic rf_addr_t rand_addr();
    logic [31:0] r;
    r = $urandom;
    return {3'b000, r[1:0]};
  endfunction

  // Mode 0 forwarding, 1 load-use, 2 JALR, 3 CSR and WFI, 4 deassert
  task automatic drive_random(input int mode);
    rs1_addr = rand_addr();
    rs2_addr = rand_addr();
    rs1_re = coin(75);
    rs2_re = coin(75);
    id_valid = coin(80);
    id_jalr = coin(20);
    id_csr = coin(20);
    id_bus_err = coin(15);
    id_trigger = coin(15);
    ex_valid = coin(75);
    ex_rf_we = coin(75);
    ex_waddr = rand_addr();
    ex_lsu = coin(25);
    ex_csr = coin(15);
    ex_wfi = coin(10);
    wb_valid = coin(75);
    wb_rf_we = coin(75);
    wb_waddr = rand_addr();
    wb_lsu = coin(25);
    wb_csr = coin(15);
    wb_ready = coin(50);
    case (mode)
      // Every stall source is off so the raw selects reach the outputs
      0: begin
        ex_lsu = 1'b0;
        wb_lsu = 1'b0;
        id_jalr = 1'b0;
        id_csr = 1'b0;
        ex_wfi = 1'b0;
      end
      1: begin
        ex_lsu = coin(60);
        wb_lsu = coin(60);
        id_csr = 1'b0;
        ex_wfi = 1'b0;
      end
      // Low read enable on rs1 shows that a JALR ignores it
      2: begin
        id_valid = coin(90);
        id_jalr = coin(85);
        rs1_re = coin(30);
        id_csr = 1'b0;
        ex_wfi = 1'b0;
      end
      // No load or JALR, so CSR and WFI are the only halt sources
      3: begin
        ex_lsu = 1'b0;
        wb_lsu = 1'b0;
        id_jalr = 1'b0;
        id_csr = coin(60);
        ex_csr = coin(40);
        wb_csr = coin(40);
        ex_wfi = coin(25);
      end
      default: begin
        id_bus_err = coin(40);
        id_trigger = coin(40);
      end
    endcase
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_val(input string name, input logic [1:0] exp, input logic [1:0] act);
    assert (act === exp) else begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_outputs();
    check_val("op_a_sel_o", exp_op_a, op_a_sel);
    check_val("op_b_sel_o", exp_op_b, op_b_sel);
    check_val("jalr_sel_o", {1'b0, exp_jalr_sel}, {1'b0, jalr_sel});
    check_val("load_stall_o", {1'b0, exp_load}, {1'b0, load_stall});
    check_val("jalr_stall_o", {1'b0, exp_jalr}, {1'b0, jalr_stall});
    check_val("csr_stall_o", {1'b0, exp_csr}, {1'b0, csr_stall});
    check_val("wfi_stall_o", {1'b0, exp_wfi}, {1'b0, wfi_stall});
    check_val("halt_id_o", {1'b0, exp_halt}, {1'b0, halt_id});
    check_val("deassert_we_o", {1'b0, exp_deassert}, {1'b0, deassert_we});
  endtask

  // Drive on the falling edge, check one ns before the rising edge
  task automatic run_test(input int mode, input string name);
    int i;
    int errors_before;
    int focus;
    logic hit;
    errors_before = error_count;
    focus = 0;
    for (i = 0; i < VECTORS; i++) begin
      @(negedge clk);
      drive_random(mode);
      predict();
      case (mode)
        0: hit = (exp_op_a != FWD_REGFILE) || (exp_op_b != FWD_REGFILE);
        1: hit = exp_load;
        2: hit = exp_jalr;
        3: hit = exp_csr | exp_wfi;
        default: hit = exp_deassert & exp_halt;
      endcase
      if (hit) focus++;
      #(HALF_PERIOD - 1);
      check_outputs();
    end
    // A test that never reaches its target event proves nothing
    assert (focus > 0) else begin
      $display("Test %s never produced the event it targets", name);
      error_count++;
    end
    if (error_count == errors_before) begin
      $display("Test %s: %0d vectors, %0d hits, passed", name, VECTORS, focus);
      tests_passed++;
    end else begin
      $display("Test %s: %0d errors, failed", name, error_count - errors_before);
      tests_failed++;
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    clk = 1'b0;
    rst = 1'b1;
    {rs1_addr, rs2_addr, ex_waddr, wb_waddr} = '0;
    {rs1_re, rs2_re, id_valid, id_jalr, id_csr, id_bus_err, id_trigger} = '0;
    {ex_valid, ex_rf_we, ex_lsu, ex_csr, ex_wfi} = '0;
    {wb_valid, wb_rf_we, wb_lsu, wb_csr, wb_ready} = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    run_test(0, "forwarding");
    run_test(1, "load_use");
    run_test(2, "jalr");
    run_test(3, "csr_wfi");
    run_test(4, "deassert");
    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: design/ctrl_bypass_top.sv
`timescale 1ns/10ps

module ctrl_bypass_top import bypass_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,

  // ID register reads
  input  rf_addr_t  rs1_addr_i,
  input  rf_addr_t  rs2_addr_i,
  input  logic      rs1_re_i,
  input  logic      rs2_re_i,

  // ID instruction
  input  logic      id_valid_i,
  input  logic      id_jalr_i,
  input  logic      id_csr_i,
  input  logic      id_bus_err_i,
  input  logic      id_trigger_i,

  // EX stage
  input  logic      ex_valid_i,
  input  logic      ex_rf_we_i,
  input  rf_addr_t  ex_waddr_i,
  input  logic      ex_lsu_i,
  input  logic      ex_csr_i,
  input  logic      ex_wfi_i,

  // WB stage
  input  logic      wb_valid_i,
  input  logic      wb_rf_we_i,
  input  rf_addr_t  wb_waddr_i,
  input  logic      wb_lsu_i,
  input  logic      wb_csr_i,
  input  logic      wb_ready_i,

  // Selects and control
  output fwd_sel_e  op_a_sel_o,
  output fwd_sel_e  op_b_sel_o,
  output jalr_sel_e jalr_sel_o,
  output logic      load_stall_o,
  output logic      jalr_stall_o,
  output logic      csr_stall_o,
  output logic      wfi_stall_o,
  output logic      deassert_we_o,
  output logic      halt_id_o
);

  // Raw selects before the halt override
  fwd_sel_e  op_a_sel_raw;
  fwd_sel_e  op_b_sel_raw;
  jalr_sel_e jalr_sel_raw;

  id_read_if  id_rd ();
  stage_wr_if ex_wr ();
  stage_wr_if wb_wr ();

  ///////////////////////////////
  // Bundle the stage views
  ///////////////////////////////

  assign id_rd.rs1_addr = rs1_addr_i;
  assign id_rd.rs2_addr = rs2_addr_i;
  assign id_rd.rs1_re   = rs1_re_i;
  assign id_rd.rs2_re   = rs2_re_i;

  assign ex_wr.valid = ex_valid_i;
  assign ex_wr.rf_we = ex_rf_we_i;
  assign ex_wr.waddr = ex_waddr_i;
  assign ex_wr.lsu   = ex_lsu_i;
  assign ex_wr.csr   = ex_csr_i;

  assign wb_wr.valid = wb_valid_i;
  assign wb_wr.rf_we = wb_rf_we_i;
  assign wb_wr.waddr = wb_waddr_i;
  assign wb_wr.lsu   = wb_lsu_i;
  assign wb_wr.csr   = wb_csr_i;

  operand_forward u_operand_forward (
    .rd_i       (id_rd),
    .ex_i       (ex_wr),
    .wb_i       (wb_wr),
    .op_a_sel_o (op_a_sel_raw),
    .op_b_sel_o (op_b_sel_raw),
    .jalr_sel_o (jalr_sel_raw)
  );

  // Stall outputs leave the block straight from here
  hazard_detect u_hazard_detect (
    .rd_i         (id_rd),
    .ex_i         (ex_wr),
    .wb_i         (wb_wr),
    .id_valid_i   (id_valid_i),
    .id_jalr_i    (id_jalr_i),
    .id_csr_i     (id_csr_i),
    .ex_wfi_i     (ex_wfi_i),
    .wb_ready_i   (wb_ready_i),
    .load_stall_o (load_stall_o),
    .jalr_stall_o (jalr_stall_o),
    .csr_stall_o  (csr_stall_o),
    .wfi_stall_o  (wfi_stall_o)
  );

  issue_ctrl u_issue_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .load_stall_i  (load_stall_o),
    .jalr_stall_i  (jalr_stall_o),
    .csr_stall_i   (csr_stall_o),
    .wfi_stall_i   (wfi_stall_o),
    .id_bus_err_i  (id_bus_err_i),
    .id_trigger_i  (id_trigger_i),
    .id_valid_i    (id_valid_i),
    .op_a_sel_i    (op_a_sel_raw),
    .op_b_sel_i    (op_b_sel_raw),
    .jalr_sel_i    (jalr_sel_raw),
    .halt_id_o     (halt_id_o),
    .deassert_we_o (deassert_we_o),
    .op_a_sel_o    (op_a_sel_o),
    .op_b_sel_o    (op_b_sel_o),
    .jalr_sel_o    (jalr_sel_o)
  );

endmodule

// File: design/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl import bypass_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      load_stall_i,
  input  logic      jalr_stall_i,
  input  logic      csr_stall_i,
  input  logic      wfi_stall_i,
  input  logic      id_bus_err_i,
  input  logic      id_trigger_i,
  input  logic      id_valid_i,
  input  fwd_sel_e  op_a_sel_i,
  input  fwd_sel_e  op_b_sel_i,
  input  jalr_sel_e jalr_sel_i,
  output logic      halt_id_o,
  output logic      deassert_we_o,
  output fwd_sel_e  op_a_sel_o,
  output fwd_sel_e  op_b_sel_o,
  output jalr_sel_e jalr_sel_o
);

  // Any single hazard holds the instruction in ID
  assign halt_id_o = load_stall_i || jalr_stall_i || csr_stall_i || wfi_stall_i;

  // A fetch error or a trigger hit turns the ID instruction into a bubble
  // It still travels down the pipe, but must not write the register file
  assign deassert_we_o = id_valid_i && (id_bus_err_i || id_trigger_i);

  // The operand muxes stay on the register file while ID is halted
  assign op_a_sel_o = halt_id_o ? FWD_REGFILE  : op_a_sel_i;
  assign op_b_sel_o = halt_id_o ? FWD_REGFILE  : op_b_sel_i;
  assign jalr_sel_o = halt_id_o ? JALR_REGFILE : jalr_sel_i;

  ///////////////////////////////
  // Checks
  ///////////////////////////////

  // A load stall needs an operand hit on EX or WB
  // That same hit moves the raw select of the operand off the register file
  a_load_stall_has_hit : assert property (
    @(posedge clk_i) disable iff (rst_i)
    load_stall_i |-> (op_a_sel_i != FWD_REGFILE) || (op_b_sel_i != FWD_REGFILE)
  ) else $error("Load stall raised without an operand hit on EX or WB");

endmodule

// File: design/hazard_detect.sv
`timescale 1ns/10ps

module hazard_detect import bypass_pkg::*; (
  id_read_if.consumer  rd_i,
  stage_wr_if.consumer ex_i,
  stage_wr_if.consumer wb_i,
  input  logic         id_valid_i,
  input  logic         id_jalr_i,
  input  logic         id_csr_i,
  input  logic         ex_wfi_i,
  input  logic         wb_ready_i,
  output logic         load_stall_o,
  output logic         jalr_stall_o,
  output logic         csr_stall_o,
  output logic         wfi_stall_o
);

  // Stage write qualifiers
  logic ex_wr_rd;
  logic wb_wr_rd;

  // Operand port hits per stage with both ports folded together
  logic any_ex_match;
  logic any_wb_match;

  // JALR target hits where the JALR itself implies the read
  logic jalr_ex_match;
  logic jalr_wb_match;

  // Valid instruction classes in ID
  logic jalr_id;
  logic csr_id;

  // CSR access somewhere downstream of ID
  logic csr_in_ex_wb;

  assign ex_wr_rd = ex_i.valid && ex_i.rf_we;
  assign wb_wr_rd = wb_i.valid && wb_i.rf_we;

  assign any_ex_match = port_match(rd_i.rs1_addr, rd_i.rs1_re, ex_i.waddr, ex_wr_rd) ||
                        port_match(rd_i.rs2_addr, rd_i.rs2_re, ex_i.waddr, ex_wr_rd);
  assign any_wb_match = port_match(rd_i.rs1_addr, rd_i.rs1_re, wb_i.waddr, wb_wr_rd) ||
                        port_match(rd_i.rs2_addr, rd_i.rs2_re, wb_i.waddr, wb_wr_rd);

  assign jalr_ex_match = port_match(rd_i.rs1_addr, 1'b1, ex_i.waddr, ex_wr_rd);
  assign jalr_wb_match = port_match(rd_i.rs1_addr, 1'b1, wb_i.waddr, wb_wr_rd);

  assign jalr_id = id_valid_i && id_jalr_i;
  assign csr_id  = id_valid_i && id_csr_i;

  assign csr_in_ex_wb = (ex_i.valid && ex_i.csr) || (wb_i.valid && wb_i.csr);

  ////////////////////////////////
  // Stall terms
  ////////////////////////////////

  // Load data is not available in EX at all
  // In WB it only exists once the data bus has answered
  assign load_stall_o = (any_ex_match && ex_i.lsu) ||
                        (any_wb_match && wb_i.lsu && !wb_ready_i);

  // The jump target path takes no EX result and no load result from WB
  // ALU results in WB go through the JALR forward instead
  assign jalr_stall_o = jalr_id && (jalr_ex_match || (jalr_wb_match && wb_i.lsu));

  // Any CSR in ID waits for all older CSR accesses to retire
  assign csr_stall_o = csr_id && csr_in_ex_wb;

  // Nothing may issue behind a WFI until it leaves EX
  assign wfi_stall_o = ex_i.valid && ex_wfi_i;

endmodule

// File: design/operand_forward.sv
`timescale 1ns/10ps

module operand_forward import bypass_pkg::*; (
  id_read_if.consumer  rd_i,
  stage_wr_if.consumer ex_i,
  stage_wr_if.consumer wb_i,
  output fwd_sel_e     op_a_sel_o,
  output fwd_sel_e     op_b_sel_o,
  output jalr_sel_e    jalr_sel_o
);

  // Stage write qualifiers
  logic ex_wr_rd;
  logic wb_wr_rd;

  // Per port match against each stage
  logic rs1_ex_match;
  logic rs2_ex_match;
  logic rs1_wb_match;
  logic rs2_wb_match;

  // A stage only produces a result when it is valid and writes the register file
  assign ex_wr_rd = ex_i.valid && ex_i.rf_we;
  assign wb_wr_rd = wb_i.valid && wb_i.rf_we;

  assign rs1_ex_match = port_match(rd_i.rs1_addr, rd_i.rs1_re, ex_i.waddr, ex_wr_rd);
  assign rs2_ex_match = port_match(rd_i.rs2_addr, rd_i.rs2_re, ex_i.waddr, ex_wr_rd);
  assign rs1_wb_match = port_match(rd_i.rs1_addr, rd_i.rs1_re, wb_i.waddr, wb_wr_rd);
  assign rs2_wb_match = port_match(rd_i.rs2_addr, rd_i.rs2_re, wb_i.waddr, wb_wr_rd);

  ////////////////////////////////
  // Operand select
  ////////////////////////////////

  // EX holds the younger value so it wins over WB
  always_comb begin
    op_a_sel_o = FWD_REGFILE;
    op_b_sel_o = FWD_REGFILE;

    if (rs1_ex_match) begin
      op_a_sel_o = FWD_EX;
    end else if (rs1_wb_match) begin
      op_a_sel_o = FWD_WB;
    end

    if (rs2_ex_match) begin
      op_b_sel_o = FWD_EX;
    end else if (rs2_wb_match) begin
      op_b_sel_o = FWD_WB;
    end
  end

  ////////////////////////////////
  // JALR target select
  ////////////////////////////////

  // A JALR always reads rs1, so the read enable is not checked here
  // An EX hit on the target is covered by the JALR stall instead
  assign jalr_sel_o = port_match(rd_i.rs1_addr, 1'b1, wb_i.waddr, wb_wr_rd) ? JALR_WB
                                                                            : JALR_REGFILE;

  // Forwarding for register 0 would corrupt the hard-wired zero in the operand path
  always_comb begin
    assert final (((op_a_sel_o == FWD_REGFILE) || (rd_i.rs1_addr != '0)) &&
                  ((op_b_sel_o == FWD_REGFILE) || (rd_i.rs2_addr != '0)) &&
                  ((jalr_sel_o == JALR_REGFILE) || (rd_i.rs1_addr != '0)))
      else $error("Forwarding select raised for register 0");
  end

endmodule

// File: design/id_read_if.sv
`timescale 1ns/10ps

interface id_read_if import bypass_pkg::*;;

  // Source register addresses as decoded in ID
  rf_addr_t rs1_addr;
  rf_addr_t rs2_addr;

  // Read enables from the decoder
  logic     rs1_re;
  logic     rs2_re;

  // Decoder side
  modport producer (output rs1_addr, rs2_addr, rs1_re, rs2_re);

  // Forwarding and hazard side
  modport consumer (input rs1_addr, rs2_addr, rs1_re, rs2_re);

endinterface

// File: design/stage_wr_if.sv
`timescale 1ns/10ps

interface stage_wr_if import bypass_pkg::*;;

  // Instruction in this stage is live
  logic     valid;

  // Instruction writes the integer register file
  logic     rf_we;

  // Destination register of the instruction
  rf_addr_t waddr;

  // Instruction is a load or store handled by the LSU
  logic     lsu;

  // Instruction is a CSR access
  logic     csr;

  // The pipeline register side drives the view
  modport producer (output valid, rf_we, waddr, lsu, csr);

  // The bypass and hazard units only look at it
  modport consumer (input valid, rf_we, waddr, lsu, csr);

endinterface

// File: design/bypass_pkg.sv
package bypass_pkg;

  //////////////////////////////
  // Widths and address type
  //////////////////////////////

  // The integer register file has 32 entries
  localparam int unsigned REG_ADDR_W = 5;

  // Width of the operand forwarding select
  localparam int unsigned FWD_SEL_W  = 2;

  // Width of the JALR target select
  localparam int unsigned JALR_SEL_W = 1;

  // Register 0 reads as zero, so it never forwards and never hazards
  typedef logic [REG_ADDR_W-1:0] rf_addr_t;

  //////////////////////////////
  // Mux select encodings
  //////////////////////////////

  // Source of an ID operand
  typedef enum logic [FWD_SEL_W-1:0] {
    FWD_REGFILE = 2'b00,
    FWD_EX      = 2'b01,
    FWD_WB      = 2'b10
  } fwd_sel_e;

  // Source of the JALR target, WB only since EX results arrive too late
  typedef enum logic [JALR_SEL_W-1:0] {
    JALR_REGFILE = 1'b0,
    JALR_WB      = 1'b1
  } jalr_sel_e;

  // True when an enabled nonzero read address hits a stage that writes rd
  function automatic logic port_match(rf_addr_t raddr, logic re, rf_addr_t waddr, logic wr_rd);
    return re && (|raddr) && (raddr == waddr) && wr_rd;
  endfunction

endpackage
